// ==== id_stage.f ====
+incdir+include
rtl/id_pkg.sv
rtl/regfile_2r1w.sv
rtl/imm_gen.sv
rtl/instr_decoder.sv
rtl/id_stage.sv
tb/tb_id_stage.sv

// ==== include/id_macros.svh ====
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

`define XLEN 64 // data path width
`define ILEN 32 // instruction word width
`define REG_AW 5 // register address width
`define NUM_REGS 32

// base opcodes, bits [6:0]
`define OPC_LUI 7'b0110111
`define OPC_AUIPC 7'b0010111
`define OPC_JAL 7'b1101111
`define OPC_JALR 7'b1100111
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD 7'b0000011
`define OPC_STORE 7'b0100011
`define OPC_OP_IMM 7'b0010011
`define OPC_OP 7'b0110011
`define OPC_OP_IMM_32 7'b0011011 // rv64 word forms
`define OPC_OP_32 7'b0111011

// funct3 for OP, OP-IMM and word forms
`define F3_ADD_SUB 3'b000
`define F3_SLL 3'b001
`define F3_SLT 3'b010
`define F3_SLTU 3'b011
`define F3_XOR 3'b100
`define F3_SR 3'b101 // srl/sra, split by funct7
`define F3_OR 3'b110
`define F3_AND 3'b111
`define F3_JALR 3'b000

// branch conditions
`define F3_BEQ 3'b000
`define F3_BNE 3'b001
`define F3_BLT 3'b100
`define F3_BGE 3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

// load / store widths
`define F3_LB 3'b000
`define F3_LH 3'b001
`define F3_LW 3'b010
`define F3_LD 3'b011
`define F3_LBU 3'b100
`define F3_LHU 3'b101
`define F3_LWU 3'b110
`define F3_SB 3'b000
`define F3_SH 3'b001
`define F3_SW 3'b010
`define F3_SD 3'b011

`define F7_BASE 7'b0000000
`define F7_ALT 7'b0100000 // sub / sra

`endif

// ==== rtl/id_pkg.sv ====
`include "id_macros.svh"

package id_pkg;

	// R-type field layout
	typedef struct packed {
		logic [6:0] funct7;
		logic [`REG_AW-1:0] rs2;
		logic [`REG_AW-1:0] rs1;
		logic [2:0] funct3;
		logic [`REG_AW-1:0] rd;
		logic [6:0] opcode;
	} instr_r_t;

	// I-type field layout, immediate in the top 12 bits
	typedef struct packed {
		logic [11:0] imm12;
		logic [`REG_AW-1:0] rs1;
		logic [2:0] funct3;
		logic [`REG_AW-1:0] rd;
		logic [6:0] opcode;
	} instr_i_t;

	typedef union packed {
		instr_r_t r; // decoder view
		instr_i_t i; // immediate / register read view
	} instr_t;

	typedef enum logic [2:0] {
		FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J
	} fmt_e;

	typedef enum logic [3:0] {
		ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, LUI, AUIPC
	} alu_op_e;

	typedef enum logic [2:0] {
		BEQ, BNE, BLT, BGE, BLTU, BGEU
	} br_type_e;

	typedef enum logic [1:0] {
		B, HW, W, DW
	} mem_unit_e;

	typedef enum logic [1:0] {
		NONE, RS1, RS1_RS2
	} chk_regs_e;

	typedef struct packed {
		logic en;
		logic [`REG_AW-1:0] addr;
		logic [`XLEN-1:0] data;
	} wb_wr_t;

	// source operands seen by the stall unit
	typedef struct packed {
		logic [`REG_AW-1:0] rs1;
		logic [`REG_AW-1:0] rs2;
		chk_regs_e check;
	} hazard_t;

	typedef struct packed {
		logic valid; // legal encoding
		fmt_e format;
		alu_op_e alu_op;
		logic alu_src; // second operand is imm
		logic is_branch;
		br_type_e br_type;
		logic mem_rd;
		logic mem_wr;
		logic mem_to_reg;
		mem_unit_e mem_unit;
		logic mem_signed;
		logic rf_wr;
		logic [`REG_AW-1:0] rf_wr_addr;
		logic word_op; // 32-bit op, result sign-extended
	} dec_ctrl_t;

	typedef struct packed {
		dec_ctrl_t ctrl;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] rs1_data;
		logic [`XLEN-1:0] rs2_data;
		logic [`XLEN-1:0] imm;
	} id_out_t;

endpackage

// ==== rtl/id_stage.sv ====
`include "id_macros.svh"

module id_stage (
	input logic clk,
	input logic rst_n,
	input id_pkg::instr_t i_if_instr,
	input logic i_if_valid,
	input logic [`XLEN-1:0] i_if_pc,
	input logic i_ex_ready,
	input logic i_ex_branch_taken,
	input logic i_ex_jump_taken,
	input id_pkg::wb_wr_t i_wb,
	output logic o_id_ready,
	output id_pkg::hazard_t o_hazard,
	output id_pkg::id_out_t o_id2ex
);

	logic [`XLEN-1:0] rs1_data;
	logic [`XLEN-1:0] rs2_data;
	logic [`XLEN-1:0] imm;
	id_pkg::dec_ctrl_t ctrl;
	id_pkg::chk_regs_e check;
	id_pkg::id_out_t id2ex_d;
	logic accept; // slot moves on to execute

	regfile_2r1w u_regfile (
		.clk(clk),
		.i_raddr_a(i_if_instr.i.rs1),
		.i_raddr_b(i_if_instr.r.rs2),
		.i_wb(i_wb),
		.o_rdata_a(rs1_data),
		.o_rdata_b(rs2_data)
	);

	instr_decoder u_decoder (
		.i_instr(i_if_instr),
		.o_ctrl(ctrl),
		.o_check(check)
	);

	imm_gen u_imm_gen (
		.i_instr(i_if_instr),
		.i_format(ctrl.format),
		.o_imm(imm)
	);

	assign accept = i_if_valid && i_ex_ready && !i_ex_branch_taken && !i_ex_jump_taken;

	assign id2ex_d.ctrl = ctrl;
	assign id2ex_d.pc = i_if_pc;
	assign id2ex_d.rs1_data = rs1_data;
	assign id2ex_d.rs2_data = rs2_data;
	assign id2ex_d.imm = imm;

	// back-pressure and flushes both turn into a bubble, fetch re-presents
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_id2ex <= '0;
		end else if (accept) begin
			o_id2ex <= id2ex_d;
		end else begin
			o_id2ex <= '0;
		end
	end

	assign o_id_ready = i_ex_ready; // fetch stalls with execute

	assign o_hazard.rs1 = i_if_instr.i.rs1;
	assign o_hazard.rs2 = i_if_instr.r.rs2;
	assign o_hazard.check = check;

	a_flush_gives_bubble: assert property (
		@(posedge clk) disable iff (!rst_n)
		(i_ex_branch_taken || i_ex_jump_taken) |=> !o_id2ex.ctrl.valid
	) else $error("valid slot passed to execute after a flush");

endmodule

// ==== rtl/imm_gen.sv ====
`include "id_macros.svh"

module imm_gen (
	input id_pkg::instr_t i_instr,
	input id_pkg::fmt_e i_format,
	output logic [`XLEN-1:0] o_imm
);

	logic sign; // instr[31] for every format

	assign sign = i_instr.i.imm12[11];

	// instr[11:7] is rd, instr[19:12] is {rs1, funct3} in the I view
	always_comb begin
		case (i_format)
			id_pkg::FMT_I: begin
				o_imm = {{(`XLEN-12){sign}}, i_instr.i.imm12};
			end
			id_pkg::FMT_S: begin
				o_imm = {{(`XLEN-12){sign}}, i_instr.i.imm12[11:5], i_instr.i.rd};
			end
			id_pkg::FMT_B: begin
				o_imm = {{(`XLEN-13){sign}}, sign,
					i_instr.i.rd[0], // instr[7]
					i_instr.i.imm12[10:5],
					i_instr.i.rd[4:1],
					1'b0};
			end
			id_pkg::FMT_U: begin
				o_imm = {{(`XLEN-`ILEN){sign}}, i_instr.i.imm12, i_instr.i.rs1,
					i_instr.i.funct3, 12'b0};
			end
			id_pkg::FMT_J: begin
				o_imm = {{(`XLEN-21){sign}}, sign,
					i_instr.i.rs1, i_instr.i.funct3, // instr[19:12]
					i_instr.i.imm12[0], // instr[20]
					i_instr.i.imm12[10:1],
					1'b0};
			end
			default: begin
				o_imm = '0; // R format has no immediate
			end
		endcase
	end

endmodule

// ==== rtl/instr_decoder.sv ====
`include "id_macros.svh"

module instr_decoder (
	input id_pkg::instr_t i_instr,
	output id_pkg::dec_ctrl_t o_ctrl,
	output id_pkg::chk_regs_e o_check
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic word_form; // OP-32 / OP-IMM-32
	logic shamt_hi_ok; // shamt[5] only legal on 64-bit shifts

	assign opcode = i_instr.r.opcode;
	assign funct3 = i_instr.r.funct3;
	assign funct7 = i_instr.r.funct7;
	assign word_form = (opcode == `OPC_OP_32) || (opcode == `OPC_OP_IMM_32);
	assign shamt_hi_ok = !(word_form && funct7[0]);

	always_comb begin
		o_ctrl = '0; // unmatched opcode stays invalid
		o_check = id_pkg::NONE;
		case (opcode)
			`OPC_LUI: begin
				o_ctrl.valid = 1'b1;
				o_ctrl.format = id_pkg::FMT_U;
				o_ctrl.alu_op = id_pkg::LUI;
				o_ctrl.alu_src = 1'b1;
				o_ctrl.rf_wr = 1'b1;
			end
			`OPC_AUIPC: begin
				o_ctrl.valid = 1'b1;
				o_ctrl.format = id_pkg::FMT_U;
				o_ctrl.alu_op = id_pkg::AUIPC;
				o_ctrl.alu_src = 1'b1;
				o_ctrl.rf_wr = 1'b1;
			end
			`OPC_JAL: begin
				o_ctrl.valid = 1'b1;
				o_ctrl.format = id_pkg::FMT_J;
				o_ctrl.alu_op = id_pkg::ADD; // link address
				o_ctrl.alu_src = 1'b1;
				o_ctrl.is_branch = 1'b1;
				o_ctrl.rf_wr = 1'b1;
			end
			`OPC_JALR: begin
				o_ctrl.valid = (funct3 == `F3_JALR);
				o_ctrl.format = id_pkg::FMT_I;
				o_ctrl.alu_op = id_pkg::ADD;
				o_ctrl.alu_src = 1'b1;
				o_ctrl.is_branch = 1'b1;
				o_ctrl.rf_wr = o_ctrl.valid;
				o_check = id_pkg::RS1;
			end
			`OPC_BRANCH: begin
				o_ctrl.valid = 1'b1;
				o_ctrl.format = id_pkg::FMT_B;
				o_ctrl.alu_op = id_pkg::SUB; // compare by subtract
				o_ctrl.is_branch = 1'b1;
				o_check = id_pkg::RS1_RS2;
				case (funct3)
					`F3_BEQ: o_ctrl.br_type = id_pkg::BEQ;
					`F3_BNE: o_ctrl.br_type = id_pkg::BNE;
					`F3_BLT: o_ctrl.br_type = id_pkg::BLT;
					`F3_BGE: o_ctrl.br_type = id_pkg::BGE;
					`F3_BLTU: o_ctrl.br_type = id_pkg::BLTU;
					`F3_BGEU: o_ctrl.br_type = id_pkg::BGEU;
					default: o_ctrl.valid = 1'b0; // funct3 2 and 3
				endcase
			end
			`OPC_OP_IMM, `OPC_OP_IMM_32: begin
				o_ctrl.valid = 1'b1;
				o_ctrl.format = id_pkg::FMT_I;
				o_ctrl.alu_src = 1'b1;
				o_ctrl.word_op = word_form;
				o_check = id_pkg::RS1;
				case (funct3)
					`F3_ADD_SUB: begin
						o_ctrl.alu_op = id_pkg::ADD;
					end
					`F3_SLL: begin
						o_ctrl.alu_op = id_pkg::SLL;
						o_ctrl.valid = (funct7[6:1] == '0) && shamt_hi_ok;
					end
					`F3_SR: begin
						if (funct7[5]) begin
							o_ctrl.alu_op = id_pkg::SRA;
						end else begin
							o_ctrl.alu_op = id_pkg::SRL;
						end
						o_ctrl.valid = !funct7[6] && (funct7[4:1] == '0) && shamt_hi_ok;
					end
					`F3_SLT: begin
						o_ctrl.alu_op = id_pkg::SLT;
						o_ctrl.valid = !word_form;
					end
					`F3_SLTU: begin
						o_ctrl.alu_op = id_pkg::SLTU;
						o_ctrl.valid = !word_form;
					end
					`F3_XOR: begin
						o_ctrl.alu_op = id_pkg::XOR;
						o_ctrl.valid = !word_form;
					end
					`F3_OR: begin
						o_ctrl.alu_op = id_pkg::OR;
						o_ctrl.valid = !word_form;
					end
					default: begin
						o_ctrl.alu_op = id_pkg::AND;
						o_ctrl.valid = !word_form;
					end
				endcase
				o_ctrl.rf_wr = o_ctrl.valid;
			end
			`OPC_OP, `OPC_OP_32: begin
				o_ctrl.valid = 1'b1;
				o_ctrl.format = id_pkg::FMT_R;
				o_ctrl.word_op = word_form;
				o_check = id_pkg::RS1_RS2;
				case (funct3)
					`F3_ADD_SUB: begin
						if (funct7 == `F7_ALT) begin
							o_ctrl.alu_op = id_pkg::SUB;
						end else begin
							o_ctrl.alu_op = id_pkg::ADD;
							o_ctrl.valid = (funct7 == `F7_BASE);
						end
					end
					`F3_SR: begin
						if (funct7 == `F7_ALT) begin
							o_ctrl.alu_op = id_pkg::SRA;
						end else begin
							o_ctrl.alu_op = id_pkg::SRL;
							o_ctrl.valid = (funct7 == `F7_BASE);
						end
					end
					`F3_SLL: begin
						o_ctrl.alu_op = id_pkg::SLL;
						o_ctrl.valid = (funct7 == `F7_BASE);
					end
					`F3_SLT: o_ctrl.alu_op = id_pkg::SLT;
					`F3_SLTU: o_ctrl.alu_op = id_pkg::SLTU;
					`F3_XOR: o_ctrl.alu_op = id_pkg::XOR;
					`F3_OR: o_ctrl.alu_op = id_pkg::OR;
					default: o_ctrl.alu_op = id_pkg::AND;
				endcase
				// logic ops and compares have no word form
				if (funct3 != `F3_ADD_SUB && funct3 != `F3_SR && funct3 != `F3_SLL) begin
					o_ctrl.valid = (funct7 == `F7_BASE) && !word_form;
				end
				o_ctrl.rf_wr = o_ctrl.valid;
			end
			`OPC_LOAD: begin
				o_ctrl.valid = 1'b1;
				o_ctrl.format = id_pkg::FMT_I;
				o_ctrl.alu_op = id_pkg::ADD; // address = rs1 + imm
				o_ctrl.alu_src = 1'b1;
				o_ctrl.mem_signed = 1'b1;
				o_check = id_pkg::RS1;
				case (funct3)
					`F3_LB: o_ctrl.mem_unit = id_pkg::B;
					`F3_LH: o_ctrl.mem_unit = id_pkg::HW;
					`F3_LW: o_ctrl.mem_unit = id_pkg::W;
					`F3_LD: o_ctrl.mem_unit = id_pkg::DW;
					`F3_LBU: begin
						o_ctrl.mem_unit = id_pkg::B;
						o_ctrl.mem_signed = 1'b0;
					end
					`F3_LHU: begin
						o_ctrl.mem_unit = id_pkg::HW;
						o_ctrl.mem_signed = 1'b0;
					end
					`F3_LWU: begin
						o_ctrl.mem_unit = id_pkg::W;
						o_ctrl.mem_signed = 1'b0;
					end
					default: o_ctrl.valid = 1'b0; // no LDU in rv64
				endcase
				o_ctrl.mem_rd = o_ctrl.valid;
				o_ctrl.mem_to_reg = o_ctrl.valid;
				o_ctrl.rf_wr = o_ctrl.valid;
			end
			`OPC_STORE: begin
				o_ctrl.valid = 1'b1;
				o_ctrl.format = id_pkg::FMT_S;
				o_ctrl.alu_op = id_pkg::ADD;
				o_ctrl.alu_src = 1'b1;
				o_check = id_pkg::RS1_RS2; // rs2 is the store data
				case (funct3)
					`F3_SB: o_ctrl.mem_unit = id_pkg::B;
					`F3_SH: o_ctrl.mem_unit = id_pkg::HW;
					`F3_SW: o_ctrl.mem_unit = id_pkg::W;
					`F3_SD: o_ctrl.mem_unit = id_pkg::DW;
					default: o_ctrl.valid = 1'b0;
				endcase
				o_ctrl.mem_wr = o_ctrl.valid;
			end
			default: begin
				o_ctrl.valid = 1'b0;
			end
		endcase
		if (o_ctrl.rf_wr) begin
			o_ctrl.rf_wr_addr = i_instr.r.rd;
		end
	end

	// holds across every opcode group, each sets its own write enables
	a_invalid_no_write: assert property (
		@(i_instr) !o_ctrl.valid |-> (!o_ctrl.rf_wr && !o_ctrl.mem_wr)
	) else $error("illegal encoding with a write enable set");

endmodule

// ==== rtl/regfile_2r1w.sv ====
`include "id_macros.svh"

module regfile_2r1w (
	input logic clk,
	input logic [`REG_AW-1:0] i_raddr_a,
	input logic [`REG_AW-1:0] i_raddr_b,
	input id_pkg::wb_wr_t i_wb,
	output logic [`XLEN-1:0] o_rdata_a,
	output logic [`XLEN-1:0] o_rdata_b
);

	logic [`XLEN-1:0] regs [1:`NUM_REGS-1]; // x0 has no storage

	always_ff @(posedge clk) begin
		if (i_wb.en && (i_wb.addr != '0)) begin
			regs[i_wb.addr] <= i_wb.data;
		end
	end

	// stored contents only, a write in this cycle shows next cycle
	always_comb begin
		o_rdata_a = '0;
		o_rdata_b = '0;
		if (i_raddr_a != '0) begin
			o_rdata_a = regs[i_raddr_a];
		end
		if (i_raddr_b != '0) begin
			o_rdata_b = regs[i_raddr_b];
		end
	end

	a_x0_reads_zero: assert property (
		@(posedge clk)
		((i_raddr_a == '0) |-> (o_rdata_a == '0)) and
		((i_raddr_b == '0) |-> (o_rdata_b == '0))
	) else $error("x0 read returned nonzero data");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the decode stage testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f id_stage.f \
	--top-module tb_id_stage -o sim_id_stage > build.log 2>&1 \
	&& ./obj_dir/sim_id_stage > sim.log 2>&1 \
	|| { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "^TB PASSED$" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// ==== tb/tb_id_stage.sv ====
`include "id_macros.svh"

module tb_id_stage;

	localparam int RESET_CYC = 16;
	localparam int N_WB = 48; // all 32 registers, then random ones
	localparam int N_WORDS = 96;
	localparam int N_MIXED = 160;
	localparam int TOTAL_CYC = RESET_CYC + N_WB + 4 * N_WORDS + N_MIXED + 4;
	localparam int TIMEOUT_CYC = 4 * TOTAL_CYC;
	localparam int K_OP = 0; // legal register-register ops
	localparam int K_ALU = 1;
	localparam int K_IMM = 2;
	localparam int K_MEM = 3;

	logic clk;
	logic rst_n;
	id_pkg::instr_t instr;
	logic if_valid;
	logic [`XLEN-1:0] if_pc;
	logic ex_ready;
	logic br_taken;
	logic jmp_taken;
	id_pkg::wb_wr_t wb;
	logic id_ready;
	id_pkg::hazard_t hazard;
	id_pkg::id_out_t id2ex;

	logic [31:0] lfsr = 32'ha6f1;
	logic [`XLEN-1:0] shadow [0:`NUM_REGS-1]; // mirror of writeback writes
	id_pkg::id_out_t model; // expected word for the slot on the inputs now
	id_pkg::id_out_t exp_q;
	id_pkg::hazard_t exp_hazard;
	logic bubble_q; // expected output is a bubble
	logic accept;
	string test_name = "reset";
	int n_err = 0;
	int n_accepted = 0;
	int n_bubbles = 0;
	int n_cycles = 0;

	id_stage u_id_stage (
		.clk(clk),
		.rst_n(rst_n),
		.i_if_instr(instr),
		.i_if_valid(if_valid),
		.i_if_pc(if_pc),
		.i_ex_ready(ex_ready),
		.i_ex_branch_taken(br_taken),
		.i_ex_jump_taken(jmp_taken),
		.i_wb(wb),
		.o_id_ready(id_ready),
		.o_hazard(hazard),
		.o_id2ex(id2ex)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int k = 0; k < n; k++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [`XLEN-1:0] shadow_read(input logic [`REG_AW-1:0] a);
		return (a == '0) ? '0 : shadow[a];
	endfunction

	function automatic id_pkg::alu_op_e alu_of(input logic [2:0] f3, input logic alt);
		case (f3)
			`F3_ADD_SUB: return alt ? id_pkg::SUB : id_pkg::ADD;
			`F3_SLL: return id_pkg::SLL;
			`F3_SLT: return id_pkg::SLT;
			`F3_SLTU: return id_pkg::SLTU;
			`F3_XOR: return id_pkg::XOR;
			`F3_SR: return alt ? id_pkg::SRA : id_pkg::SRL;
			`F3_OR: return id_pkg::OR;
			default: return id_pkg::AND;
		endcase
	endfunction

	function automatic id_pkg::chk_regs_e exp_check(input logic [6:0] opc);
		case (opc)
			`OPC_BRANCH, `OPC_STORE, `OPC_OP, `OPC_OP_32: return id_pkg::RS1_RS2;
			`OPC_JALR, `OPC_LOAD, `OPC_OP_IMM, `OPC_OP_IMM_32: return id_pkg::RS1;
			default: return id_pkg::NONE;
		endcase
	endfunction

	function automatic logic [`XLEN-1:0] exp_imm(input logic [31:0] w, input id_pkg::fmt_e f);
		case (f)
			id_pkg::FMT_I: return {{(`XLEN-12){w[31]}}, w[31:20]};
			id_pkg::FMT_S: return {{(`XLEN-12){w[31]}}, w[31:25], w[11:7]};
			id_pkg::FMT_B: return {{(`XLEN-13){w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			id_pkg::FMT_U: return {{(`XLEN-32){w[31]}}, w[31:12], 12'b0};
			id_pkg::FMT_J: return {{(`XLEN-21){w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			default: return '0;
		endcase
	endfunction

	function automatic id_pkg::dec_ctrl_t exp_ctrl(input logic [31:0] w);
		id_pkg::dec_ctrl_t c;
		logic [6:0] f7;
		logic [2:0] f3;
		logic word;
		logic ok;
		logic writes_rd;
		f7 = w[31:25];
		f3 = w[14:12];
		word = (w[6:0] == `OPC_OP_IMM_32) || (w[6:0] == `OPC_OP_32);
		c = '0;
		ok = 1'b1;
		writes_rd = 1'b1;
		c.alu_src = 1'b1; // cleared for branches and register ops
		c.word_op = word;
		case (w[6:0])
			`OPC_LUI, `OPC_AUIPC: begin
				c.format = id_pkg::FMT_U;
				c.alu_op = (w[6:0] == `OPC_LUI) ? id_pkg::LUI : id_pkg::AUIPC;
			end
			`OPC_JAL: begin
				c.format = id_pkg::FMT_J;
				c.is_branch = 1'b1;
			end
			`OPC_JALR: begin
				c.format = id_pkg::FMT_I;
				c.is_branch = 1'b1;
				ok = (f3 == `F3_JALR);
			end
			`OPC_BRANCH: begin
				c.format = id_pkg::FMT_B;
				c.alu_op = id_pkg::SUB;
				c.alu_src = 1'b0;
				c.is_branch = 1'b1;
				c.br_type = id_pkg::br_type_e'(f3[2] ? f3 - 3'd2 : f3); // 0,1,4..7 packed
				ok = (f3[2:1] != 2'b01);
				writes_rd = 1'b0;
			end
			`OPC_LOAD: begin
				c.format = id_pkg::FMT_I;
				c.mem_unit = id_pkg::mem_unit_e'(f3[1:0]);
				c.mem_signed = !f3[2];
				ok = (f3 != 3'b111);
				c.mem_rd = ok;
				c.mem_to_reg = ok;
			end
			`OPC_STORE: begin
				c.format = id_pkg::FMT_S;
				c.mem_unit = id_pkg::mem_unit_e'(f3[1:0]);
				ok = !f3[2];
				c.mem_wr = ok;
				writes_rd = 1'b0;
			end
			`OPC_OP_IMM, `OPC_OP_IMM_32: begin
				c.format = id_pkg::FMT_I;
				c.alu_op = alu_of(f3, f7[5] && (f3 == `F3_SR));
				if (f3 == `F3_SLL) begin
					ok = (f7[6:1] == '0) && !(word && f7[0]);
				end else if (f3 == `F3_SR) begin
					ok = ((f7[6:1] & 6'b101111) == '0) && !(word && f7[0]);
				end else begin
					ok = !word || (f3 == `F3_ADD_SUB);
				end
			end
			`OPC_OP, `OPC_OP_32: begin
				c.format = id_pkg::FMT_R;
				c.alu_src = 1'b0;
				c.alu_op = alu_of(f3, f7 == `F7_ALT);
				if (f3 == `F3_ADD_SUB || f3 == `F3_SR) begin
					ok = (f7 == `F7_BASE) || (f7 == `F7_ALT);
				end else begin
					ok = (f7 == `F7_BASE) && (!word || f3 == `F3_SLL);
				end
			end
			default: begin
				c = '0;
				ok = 1'b0;
			end
		endcase
		c.valid = ok;
		c.rf_wr = ok && writes_rd;
		c.rf_wr_addr = c.rf_wr ? w[11:7] : '0;
		return c;
	endfunction

	// random word of one instruction group
	function automatic logic [31:0] gen_word(input int kind);
		logic [31:0] w;
		logic [2:0] pick;
		w = take_bits(32);
		pick = 3'(take_bits(3));
		case (kind)
			K_OP: begin
				w[6:0] = `OPC_OP;
				w[31:25] = (pick[0] && (w[14:12] == `F3_ADD_SUB || w[14:12] == `F3_SR)) ?
					`F7_ALT : `F7_BASE;
			end
			K_ALU: begin
				w[6:0] = pick[1] ? (pick[0] ? `OPC_OP : `OPC_OP_32) :
					(pick[0] ? `OPC_OP_IMM : `OPC_OP_IMM_32);
				if (pick[2]) begin
					w[31:25] = w[30] ? `F7_ALT : `F7_BASE; // mostly legal, rest raw
				end
			end
			K_IMM: begin
				case (pick)
					3'd0: w[6:0] = `OPC_LUI;
					3'd1: w[6:0] = `OPC_AUIPC;
					3'd2: w[6:0] = `OPC_JAL;
					3'd3: w[6:0] = `OPC_JALR;
					3'd4: w[6:0] = `OPC_BRANCH;
					3'd5: w[6:0] = `OPC_LOAD;
					3'd6: w[6:0] = `OPC_STORE;
					default: w[6:0] = w[6:0]; // any opcode, often unmatched
				endcase
				if (pick == 3'd3 && w[20]) begin
					w[14:12] = `F3_JALR;
				end
			end
			default: begin
				w[6:0] = (pick[1:0] == 2'd1) ? `OPC_STORE :
					(pick[1:0] == 2'd2) ? `OPC_BRANCH : `OPC_LOAD;
			end
		endcase
		return w;
	endfunction

	task automatic report_value(input string what, input logic [287:0] exp_v,
		input logic [287:0] act_v);
		n_err++;
		$display("ERROR %s %s: expected %0h actual %0h", test_name, what, exp_v, act_v);
	endtask

	task automatic print_counts();
		$display("checks done: %0d accepted slots, %0d bubbles, %0d errors",
			n_accepted, n_bubbles, n_err);
	endtask

	task automatic drive_slot(input logic [31:0] w, input logic v, input logic rdy,
		input logic bt, input logic jt);
		@(posedge clk);
		instr <= w;
		if_valid <= v;
		ex_ready <= rdy;
		br_taken <= bt;
		jmp_taken <= jt;
		if_pc <= {take_bits(32), take_bits(32)};
		wb.en <= 1'b0;
	endtask

	task automatic run_words(input string name, input int kind, input int n);
		test_name = name;
		repeat (n) begin
			drive_slot(gen_word(kind), 1'b1, 1'b1, 1'b0, 1'b0);
		end
	endtask

	always @(posedge clk) begin
		if (wb.en) begin
			shadow[wb.addr] <= wb.data;
		end
	end

	assign accept = if_valid && ex_ready && !br_taken && !jmp_taken;

	always_comb begin
		model.ctrl = exp_ctrl(instr);
		model.pc = if_pc;
		model.rs1_data = shadow_read(instr[19:15]);
		model.rs2_data = shadow_read(instr[24:20]);
		model.imm = exp_imm(instr, model.ctrl.format);
		exp_hazard.rs1 = instr[19:15];
		exp_hazard.rs2 = instr[24:20];
		exp_hazard.check = exp_check(instr[6:0]);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_q <= '0;
			bubble_q <= 1'b1;
		end else begin
			exp_q <= accept ? model : '0;
			bubble_q <= !accept;
		end
	end

	always @(posedge clk) begin
		n_cycles <= n_cycles + 1;
		if (rst_n && accept) begin
			n_accepted <= n_accepted + 1;
		end else if (rst_n) begin
			n_bubbles <= n_bubbles + 1;
		end
		if (n_cycles > TIMEOUT_CYC) begin
			$display("stimulus did not finish within %0d cycles", TIMEOUT_CYC);
			print_counts();
			$display("TB FAILED");
			$finish;
		end
	end

	// outputs are compared at the falling edge, half a cycle after they settle
	a_ready: assert property (@(negedge clk) id_ready == ex_ready)
		else report_value("o_id_ready", ex_ready, id_ready);
	a_reset: assert property (@(negedge clk) !rst_n |-> id2ex == '0)
		else report_value("reset output", '0, id2ex);
	a_bubble: assert property (@(negedge clk) disable iff (!rst_n) bubble_q |-> id2ex == '0)
		else report_value("bubble", '0, id2ex);
	a_ctrl: assert property (@(negedge clk) disable iff (!rst_n)
		exp_q.ctrl.valid |-> id2ex.ctrl == exp_q.ctrl)
		else report_value("ctrl", exp_q.ctrl, id2ex.ctrl);
	a_illegal: assert property (@(negedge clk) disable iff (!rst_n)
		(!bubble_q && !exp_q.ctrl.valid) |-> (!id2ex.ctrl.valid && !id2ex.ctrl.rf_wr &&
		!id2ex.ctrl.mem_rd && !id2ex.ctrl.mem_wr))
		else report_value("illegal valid/rf_wr/mem_rd/mem_wr", '0, {id2ex.ctrl.valid,
			id2ex.ctrl.rf_wr, id2ex.ctrl.mem_rd, id2ex.ctrl.mem_wr});
	a_imm: assert property (@(negedge clk) disable iff (!rst_n)
		exp_q.ctrl.valid |-> id2ex.imm == exp_q.imm)
		else report_value("imm", exp_q.imm, id2ex.imm);
	a_pc: assert property (@(negedge clk) disable iff (!rst_n) !bubble_q |-> id2ex.pc == exp_q.pc)
		else report_value("pc", exp_q.pc, id2ex.pc);
	a_rs1: assert property (@(negedge clk) disable iff (!rst_n)
		!bubble_q |-> id2ex.rs1_data == exp_q.rs1_data)
		else report_value("rs1_data", exp_q.rs1_data, id2ex.rs1_data);
	a_rs2: assert property (@(negedge clk) disable iff (!rst_n)
		!bubble_q |-> id2ex.rs2_data == exp_q.rs2_data)
		else report_value("rs2_data", exp_q.rs2_data, id2ex.rs2_data);
	a_hazard: assert property (@(negedge clk) hazard == exp_hazard)
		else report_value("o_hazard", exp_hazard, hazard);

	initial begin
		logic [7:0] ctl;
		rst_n = 1'b0;
		instr = '0;
		if_valid = 1'b0;
		if_pc = '0;
		ex_ready = 1'b0;
		br_taken = 1'b0;
		jmp_taken = 1'b0;
		wb = '0;
		// slot seen at release is empty, registers hold nothing yet
		for (int c = 0; c < RESET_CYC; c++) begin
			drive_slot(take_bits(32), c < RESET_CYC - 1, take_bits(1) != 0, 1'b0, 1'b0);
		end
		rst_n <= 1'b1;
		test_name = "regfile";
		for (int a = 0; a < N_WB; a++) begin
			drive_slot(take_bits(32), 1'b0, 1'b1, 1'b0, 1'b0);
			wb <= {1'b1, (a < `NUM_REGS) ? 5'(a) : 5'(take_bits(5)),
				take_bits(32), take_bits(32)}; // x0 included
		end
		run_words("regfile", K_OP, N_WORDS);
		run_words("alu", K_ALU, N_WORDS);
		run_words("imm", K_IMM, N_WORDS);
		run_words("mem_branch", K_MEM, N_WORDS);
		test_name = "bubbles";
		repeat (N_MIXED) begin
			ctl = 8'(take_bits(8));
			drive_slot(gen_word(ctl[0] ? K_IMM : K_ALU), ctl[2:1] != 0, ctl[4:3] != 0,
				ctl[7:5] == 3'd0, ctl[7:5] == 3'd7);
		end
		repeat (2) begin
			drive_slot('0, 1'b0, 1'b1, 1'b0, 1'b0);
		end
		@(posedge clk);
		print_counts();
		if (n_err == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule
